// File: design/rio_params.svh
// ==============================
// widths, counts and frame timing shared by the remote-IO design
// include wherever a size or frame position is needed
// ==============================
`ifndef RIO_PARAMS_SVH
`define RIO_PARAMS_SVH

// bus widths
`define RIO_ADDR_W        4    // register address
`define RIO_DATA_W        32   // write data and register width
`define RIO_RDATA_W       8    // read bits returned over the link
`define RIO_REG_COUNT     16   // registers behind the local bus

// link framing
`define RIO_SYM_W         2    // host to target bits per clock
`define RIO_STATE_W       5    // target frame counter width
`define RIO_CMD_LAST      2    // state holding the last command symbol
`define RIO_RVALID_STATE  4    // read strobe issued here
`define RIO_LOAD_STATE    7    // read byte loaded into the transmit shifter
`define RIO_RET_FIRST     9    // first return bit on the wire
`define RIO_FRAME_LAST    18   // last state of a frame

`endif

// File: design/rio_bus_pkg.sv
// ==============================
// local bus and wishbone data types
// import where addresses, words or read bytes are declared
// ==============================
package rio_bus_pkg;

`include "rio_params.svh"

   // register address, also the wishbone address
   typedef logic [`RIO_ADDR_W-1:0] reg_addr_t;

   // full data word on wishbone and in the register block
   typedef logic [`RIO_DATA_W-1:0] bus_word_t;

   // read reply carried back over the link
   typedef logic [`RIO_RDATA_W-1:0] read_byte_t;

endpackage

// File: design/rio_link_pkg.sv
// ==============================
// link level encodings for the remote-IO frame
// import in any block that builds or decodes frames
// ==============================
package rio_link_pkg;

   // opcode bit, carried in the low bit of the start symbol
   // start symbol is {1'b0, op}, the upper 0 marks the frame
   typedef enum logic
   {
      op_write = 1'b0,
      op_read  = 1'b1
   } link_op_e;

   // host sequencer
   // idle -> send_cmd -> send_data -> finish            for writes
   // idle -> send_cmd -> turnaround -> recv -> finish   for reads
   typedef enum logic [2:0]
   {
      idle       = 3'd0,   // waiting for a wishbone strobe
      send_cmd   = 3'd1,   // start symbol and address on the wire
      send_data  = 3'd2,   // write data bytes
      turnaround = 3'd3,   // target fetching the read byte
      recv       = 3'd4,   // sampling eight return bits
      finish     = 3'd5    // ack cycle
   } host_state_e;

endpackage

// File: design/rio_local_bus_if.sv
// ==============================
// local bus from the link target to the register block
// strobes are single cycle, rdata follows rvalid by one clock
// ==============================
`timescale 1ns/1ns

interface rio_local_bus_if;
   import rio_bus_pkg::*;

   logic       wvalid;   // write strobe, addr and wdata valid
   logic       rvalid;   // read strobe, addr valid
   reg_addr_t  addr;     // register select
   bus_word_t  wdata;    // write word
   read_byte_t rdata;    // low byte of the addressed register

   // link side
   modport target (output wvalid, rvalid, addr, wdata, input rdata);

   // register side
   modport regs (input wvalid, rvalid, addr, wdata, output rdata);

endinterface

// File: design/rio_host.sv
// ==============================
// wishbone classic slave, one transfer per serial frame
// sends two bits per clock, reads back one bit per clock for reads
// ==============================
`timescale 1ns/1ns
`include "rio_params.svh"

module rio_host
(
   input  logic                   clock,
   input  logic                   arst_n,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  rio_bus_pkg::reg_addr_t wb_adr,
   input  rio_bus_pkg::bus_word_t wb_dat_w,
   output rio_bus_pkg::bus_word_t wb_dat_r,
   output logic                   wb_ack,
   output logic [`RIO_SYM_W-1:0]  link_sym,
   input  logic                   link_ret,
   input  logic                   link_ret_oe
);
   import rio_link_pkg::*;
   import rio_bus_pkg::*;

   localparam int FRAME_BITS = `RIO_ADDR_W + `RIO_DATA_W;   // symbols after the start
   localparam logic [`RIO_STATE_W-1:0] SYM_LAST = `RIO_FRAME_LAST;
   localparam logic [`RIO_STATE_W-1:0] CMD_DONE = `RIO_CMD_LAST + 1;
   localparam logic [`RIO_STATE_W-1:0] RET_FIRST = `RIO_RET_FIRST;

   host_state_e                       state;
   link_op_e                          op;        // opcode of the frame in flight
   link_op_e                          req_op;
   logic                              start;
   logic [`RIO_STATE_W-1:0]           sym_cnt;   // index of the next symbol, 0 when quiet
   logic [FRAME_BITS-1:0]             frame_sr;  // address then data, msb pair first
   bus_word_t                         data_field;
   logic [$clog2(`RIO_RDATA_W)-1:0]   rx_cnt;
   read_byte_t                        rx_sr;
   read_byte_t                        rx_next;
   logic                              ret_bit;

   assign req_op  = wb_we ? op_write : op_read;
   assign start   = (state == idle) && wb_cyc && wb_stb && (sym_cnt == '0);
   assign ret_bit = link_ret_oe ? link_ret : 1'b1;   // pull-up when target is off the line
   assign rx_next = {rx_sr[`RIO_RDATA_W-2:0], ret_bit};

   // bytes go lsb first on the wire, reads send an all-ones filler
   assign data_field = wb_we ? {wb_dat_w[7:0], wb_dat_w[15:8],
                                wb_dat_w[23:16], wb_dat_w[31:24]} : '1;

   // symbol sender, full length for every frame
   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         link_sym <= '1;   // idle symbol
         sym_cnt  <= '0;
      end
      else if (start)
      begin
         link_sym <= {1'b0, req_op};   // start marker plus opcode
         sym_cnt  <= 1;
      end
      else if (sym_cnt != '0)
      begin
         link_sym <= frame_sr[FRAME_BITS-1 -: `RIO_SYM_W];
         sym_cnt  <= (sym_cnt == SYM_LAST) ? '0 : sym_cnt + 1'b1;   // wrap at frame end
      end
      else
      begin
         link_sym <= '1;
      end
   end

   // frame shifter, only the top pair is looked at
   always_ff @(posedge clock)
   begin
      if (start)
         frame_sr <= {wb_adr, data_field};
      else
         frame_sr <= frame_sr << `RIO_SYM_W;
   end

   // sequencer
   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state  <= idle;
         op     <= op_write;
         wb_ack <= 1'b0;
         rx_cnt <= '0;
      end
      else
      begin
         wb_ack <= 1'b0;   // one cycle pulse
         case (state)
            idle:
               if (start)
               begin
                  state  <= send_cmd;
                  op     <= req_op;
                  rx_cnt <= '0;
               end
            send_cmd:
               if (sym_cnt == CMD_DONE)
                  state <= (op == op_write) ? send_data : turnaround;
            send_data:
               if (sym_cnt == '0)   // last symbol now on the wire
               begin
                  state  <= finish;
                  wb_ack <= 1'b1;
               end
            turnaround:
               if (sym_cnt == RET_FIRST)   // target drives from next cycle
                  state <= recv;
            recv:
            begin
               rx_cnt <= rx_cnt + 1'b1;
               if (rx_cnt == '1)   // eighth bit
               begin
                  state  <= finish;
                  wb_ack <= 1'b1;
               end
            end
            finish:
               state <= idle;
            default:
               state <= idle;
         endcase
      end
   end

   // read reply capture, msb arrives first
   always_ff @(posedge clock)
   begin
      if (state == recv)
         rx_sr <= rx_next;
      if ((state == recv) && (rx_cnt == '1))
         wb_dat_r <= {{(`RIO_DATA_W-`RIO_RDATA_W){1'b0}}, rx_next};   // zero extend
   end

endmodule

// File: design/rio_target.sv
// ==============================
// link target, decodes host frames into local bus strobes
// read bytes are shifted back msb first on the return line
// ==============================
`timescale 1ns/1ns
`include "rio_params.svh"

module rio_target
(
   input  logic                  clock,
   input  logic                  arst_n,
   input  logic [`RIO_SYM_W-1:0] link_sym,
   output logic                  link_ret,
   output logic                  link_ret_oe,
   rio_local_bus_if.target       bus
);
   import rio_link_pkg::*;
   import rio_bus_pkg::*;

   localparam logic [`RIO_STATE_W-1:0] CMD_AT     = `RIO_CMD_LAST;
   localparam logic [`RIO_STATE_W-1:0] RVALID_AT  = `RIO_RVALID_STATE;
   localparam logic [`RIO_STATE_W-1:0] LOAD_AT    = `RIO_LOAD_STATE;
   localparam logic [`RIO_STATE_W-1:0] FRAME_LAST = `RIO_FRAME_LAST;

   logic [`RIO_STATE_W-1:0] state;   // 0 waits for start
   logic [5:0]              rsr;     // last three symbols
   read_byte_t              tsr;     // return shifter
   link_op_e                op;

   // frame counter and control outputs
   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state       <= '0;
         op          <= op_write;
         link_ret    <= 1'b1;
         link_ret_oe <= 1'b0;
         bus.wvalid  <= 1'b0;
         bus.rvalid  <= 1'b0;
      end
      else
      begin
         if (state == '0)
            state <= {{(`RIO_STATE_W-1){1'b0}}, ~link_sym[1]};   // upper bit low starts
         else if (state == FRAME_LAST)
            state <= '0;
         else
            state <= state + 1'b1;

         if (state == CMD_AT)
            op <= link_op_e'(rsr[2]);   // low bit of the start symbol

         link_ret    <= tsr[`RIO_RDATA_W-1];   // output register
         link_ret_oe <= (op == op_read) && (state > LOAD_AT)
                        && (state != FRAME_LAST);   // line free again at state 0
         bus.wvalid  <= (state == FRAME_LAST) && (op == op_write);
         bus.rvalid  <= (state == RVALID_AT) && (op == op_read);
      end
   end

   // symbol shifters and captured fields
   always_ff @(posedge clock)
   begin
      rsr <= {rsr[3:0], link_sym};
      tsr <= (state == LOAD_AT) ? bus.rdata : {tsr[`RIO_RDATA_W-2:0], 1'b1};   // ones trail

      if (state[1:0] == 2'd2)   // every fourth state closes a field
      begin
         case (state[4:2])
            3'd0: bus.addr          <= {rsr[1:0], link_sym};
            3'd1: bus.wdata[7:0]    <= {rsr, link_sym};
            3'd2: bus.wdata[15:8]   <= {rsr, link_sym};
            3'd3: bus.wdata[23:16]  <= {rsr, link_sym};
            3'd4: bus.wdata[31:24]  <= {rsr, link_sym};
            default: ;
         endcase
      end
   end

endmodule

// File: design/rio_regs.sv
// ==============================
// sixteen registers behind the local bus
// top entry is read-only and counts accepted writes
// ==============================
`timescale 1ns/1ns
`include "rio_params.svh"

module rio_regs
(
   input  logic          clock,
   input  logic          arst_n,
   rio_local_bus_if.regs bus
);
   import rio_bus_pkg::*;

   localparam reg_addr_t COUNT_ADDR = reg_addr_t'(`RIO_REG_COUNT - 1);

   bus_word_t regs [`RIO_REG_COUNT];   // last entry is the write counter
   logic      wr_plain;                // write lands in a storage register

   assign wr_plain = bus.wvalid && (bus.addr != COUNT_ADDR);

   // storage and write counter
   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < `RIO_REG_COUNT; i++)
            regs[i] <= '0;
      end
      else
      begin
         if (wr_plain)
            regs[bus.addr] <= bus.wdata;
         if (bus.wvalid)   // every accepted write counts, its own address too
            regs[COUNT_ADDR] <= regs[COUNT_ADDR] + 1'b1;
      end
   end

   // read port, low byte only since the link carries eight bits
   always_ff @(posedge clock)
   begin
      if (bus.rvalid)
         bus.rdata <= regs[bus.addr][`RIO_RDATA_W-1:0];
   end

endmodule

// File: design/rio_top.sv
// ==============================
// remote-IO subsystem, wishbone classic slave on the outside
// host bridge and target joined by the split serial link
// ==============================
`timescale 1ns/1ns
`include "rio_params.svh"

module rio_top
(
   input  logic                   clock,
   input  logic                   arst_n,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  rio_bus_pkg::reg_addr_t wb_adr,
   input  rio_bus_pkg::bus_word_t wb_dat_w,
   output rio_bus_pkg::bus_word_t wb_dat_r,
   output logic                   wb_ack
);

   logic [`RIO_SYM_W-1:0] link_sym;      // host to target, idle is all ones
   logic                  link_ret;      // target to host
   logic                  link_ret_oe;   // target driving link_ret

   rio_local_bus_if local_bus ();

   rio_host u_rio_host
   (
      .clock       (clock),
      .arst_n      (arst_n),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .link_sym    (link_sym),
      .link_ret    (link_ret),
      .link_ret_oe (link_ret_oe)
   );

   rio_target u_rio_target
   (
      .clock       (clock),
      .arst_n      (arst_n),
      .link_sym    (link_sym),
      .link_ret    (link_ret),
      .link_ret_oe (link_ret_oe),
      .bus         (local_bus.target)
   );

   rio_regs u_rio_regs
   (
      .clock  (clock),
      .arst_n (arst_n),
      .bus    (local_bus.regs)
   );

endmodule

// File: verification/rio_clock_gen.sv
// ==============================
// testbench clock and power-on reset
// 4 ns clock, reset held low for sixteen cycles
// ==============================
`timescale 1ns/1ns

module rio_clock_gen
#(
   parameter int HALF_PERIOD  = 2,    // ns
   parameter int RESET_CYCLES = 16
)
(
   output logic clock,
   output logic arst_n
);

   initial
   begin
      clock  = 1'b0;
      arst_n = 1'b0;                             // asserted from time zero
      repeat (RESET_CYCLES) @(negedge clock);
      arst_n = 1'b1;                             // released away from the rising edge
   end

   always #HALF_PERIOD clock = ~clock;

endmodule

// File: verification/rio_assertions.sv
// ==============================
// concurrent checks on the link target
// attached to rio_target by the bind below
// ==============================
`timescale 1ns/1ns
`include "rio_params.svh"

module rio_assertions
(
   input logic clock,
   input logic arst_n,
   input logic wvalid,
   input logic rvalid,
   input logic link_ret_oe
);

   // sampled clocks after a read strobe until the frame counter is back at 0
   localparam int READ_OPEN = `RIO_FRAME_LAST - `RIO_RVALID_STATE - 1;

   int unsigned             fail_count = 0;   // failed assertions so far
   logic [`RIO_STATE_W-1:0] since_rvalid;     // clocks since the last read strobe, saturates

   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
         since_rvalid <= '1;
      else if (rvalid)
         since_rvalid <= '0;
      else if (since_rvalid != '1)
         since_rvalid <= since_rvalid + 1'b1;
   end

   strobes_exclusive: assert property (@(posedge clock) disable iff (!arst_n)
      !(wvalid && rvalid))
   else
   begin
      fail_count++;
      $error("wvalid and rvalid high in the same cycle");
   end

   strobe_single: assert property (@(posedge clock) disable iff (!arst_n)
      (wvalid || rvalid) |=> !(wvalid || rvalid))
   else
   begin
      fail_count++;
      $error("local bus strobe held longer than one cycle");
   end

   // return line only driven inside the frame of a read
   oe_read_only: assert property (@(posedge clock) disable iff (!arst_n)
      link_ret_oe |-> (since_rvalid < READ_OPEN))
   else
   begin
      fail_count++;
      $error("link_ret_oe high while no read was in progress");
   end

endmodule

bind rio_target rio_assertions u_rio_assertions
(
   .clock       (clock),
   .arst_n      (arst_n),
   .wvalid      (bus.wvalid),
   .rvalid      (bus.rvalid),
   .link_ret_oe (link_ret_oe)
);

// File: verification/rio_tb.sv
// ==============================
// directed testbench for the remote-IO subsystem
// wishbone transfers driven on falling edges, checked against a register model
// ==============================
`timescale 1ns/1ns
`include "rio_params.svh"

module rio_tb;
   import rio_bus_pkg::*;

   localparam int TRANSFERS = 68;                    // wishbone transfers over all tests
   localparam int LIMIT     = 30 * TRANSFERS + 16;   // cycles incl reset
   localparam int ACK_BOUND = 26;                    // strobe to ack, worst case
   localparam reg_addr_t COUNT_ADDR = reg_addr_t'(`RIO_REG_COUNT - 1);

   logic        clock;
   logic        arst_n;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   reg_addr_t   wb_adr;
   bus_word_t   wb_dat_w;
   bus_word_t   wb_dat_r;
   logic        wb_ack;
   bus_word_t   model [`RIO_REG_COUNT];   // expected register contents
   string       test_name;
   int unsigned errors = 0;
   int unsigned checks = 0;
   int unsigned tests_run = 0;
   int unsigned tests_failed = 0;
   int unsigned errors_before = 0;       // errors when the current test began
   int unsigned writes_done = 0;         // accepted writes since reset
   int unsigned cycles = 0;
   int unsigned assert_fails;

   rio_clock_gen u_rio_clock_gen (.clock(clock), .arst_n(arst_n));

   rio_top u_rio_top
   (
      .clock    (clock),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   // run limit
   always @(posedge clock)
   begin
      cycles++;
      if (cycles > LIMIT)
      begin
         $display("timeout: the run went past %0d cycles without finishing", LIMIT);
         $display("Some tests failed");
         $finish;
      end
   end

   task automatic check_word(input bus_word_t expected, input bus_word_t actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("** Error %s: expected 0x%08h, actual 0x%08h", test_name, expected, actual);
      end
   endtask

   task automatic check_byte(input read_byte_t expected, input read_byte_t actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("** Error %s: expected 0x%02h, actual 0x%02h", test_name, expected, actual);
      end
   endtask

   task automatic note_problem(input string what);
      errors++;
      $display("%s: %s", test_name, what);
   endtask

   // reads come back as the low byte, zero extended
   function automatic bus_word_t expected_read(input reg_addr_t adr);
      return bus_word_t'(model[adr][`RIO_RDATA_W-1:0]);
   endfunction

   // called on a falling edge, returns on the falling edge that shows ack
   task automatic run_transfer(input logic we, input reg_addr_t adr, input bus_word_t dat);
      int n;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = dat;
      n = 0;
      do
      begin
         @(negedge clock);
         n++;
      end
      while (!wb_ack && n < 2 * ACK_BOUND);
      if (!wb_ack)
         note_problem($sformatf("no ack at all within %0d cycles", n));
      else if (n > ACK_BOUND)
         note_problem($sformatf("ack took %0d cycles, more than the %0d allowed", n, ACK_BOUND));
      wb_cyc = 1'b0;   // next transfer may reassert in the same step
      wb_stb = 1'b0;
   endtask

   task automatic write_reg(input reg_addr_t adr, input bus_word_t dat);
      run_transfer(1'b1, adr, dat);
      if (adr != COUNT_ADDR)
         model[adr] = dat;
      model[COUNT_ADDR] = model[COUNT_ADDR] + 1;   // counter sees every write
      writes_done++;
   endtask

   task automatic read_reg(input reg_addr_t adr, output bus_word_t dat);
      run_transfer(1'b0, adr, '0);
      dat = wb_dat_r;
   endtask

   task automatic start_test(input string name);
      test_name     = name;
      errors_before = errors;
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors == errors_before)
         $display("%-16s passed", test_name);
      else
      begin
         tests_failed++;
         $display("%-16s FAILED with %0d errors", test_name, errors - errors_before);
      end
   endtask

   task automatic reset_state_test();
      bus_word_t rd;
      start_test("reset_state");
      repeat (20)   // bus idle, ack must stay low
      begin
         @(negedge clock);
         if (wb_ack !== 1'b0)
            note_problem("wb_ack rose while no strobe was given");
      end
      for (int a = 0; a < `RIO_REG_COUNT; a++)
      begin
         read_reg(reg_addr_t'(a), rd);
         check_word('0, rd);
      end
      finish_test();
   endtask

   task automatic write_read_test();
      bus_word_t rd;
      start_test("write_read");
      for (int a = 0; a < `RIO_REG_COUNT - 1; a++)
         write_reg(reg_addr_t'(a), $urandom);
      for (int a = 0; a < `RIO_REG_COUNT - 1; a++)
      begin
         read_reg(reg_addr_t'(a), rd);
         check_word(expected_read(reg_addr_t'(a)), rd);
      end
      finish_test();
   endtask

   task automatic byte_order_test();
      bus_word_t rd;
      start_test("byte_order");
      write_reg(reg_addr_t'(5), 32'h4433_2211);   // a different value per byte
      read_reg(reg_addr_t'(5), rd);
      check_byte(8'h11, rd[`RIO_RDATA_W-1:0]);
      check_word(32'h0000_0011, rd);
      finish_test();
   endtask

   task automatic write_counter_test();
      bus_word_t rd;
      start_test("write_counter");
      write_reg(reg_addr_t'(3), $urandom);
      write_reg(COUNT_ADDR, 32'hffff_ffff);   // only bumps the count
      write_reg(reg_addr_t'(9), $urandom);
      read_reg(COUNT_ADDR, rd);
      check_byte(read_byte_t'(writes_done % 256), rd[`RIO_RDATA_W-1:0]);
      finish_test();
   endtask

   task automatic back_to_back_test();
      bus_word_t rd;
      reg_addr_t ra;
      start_test("back_to_back");
      repeat (8)   // no idle cycle between transfers
      begin
         write_reg(reg_addr_t'($urandom), $urandom);
         ra = reg_addr_t'($urandom);
         read_reg(ra, rd);
         check_word(expected_read(ra), rd);
      end
      finish_test();
   endtask

   initial
   begin
      void'($urandom(92363));
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      for (int a = 0; a < `RIO_REG_COUNT; a++)
         model[a] = '0;   // all registers clear after reset
      wait (arst_n === 1'b1);
      @(negedge clock);
      reset_state_test();
      write_read_test();
      byte_order_test();
      write_counter_test();
      back_to_back_test();
      assert_fails = u_rio_top.u_rio_target.u_rio_assertions.fail_count;
      $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
               tests_run, tests_failed, checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

// File: compile.f
+incdir+design
design/rio_bus_pkg.sv
design/rio_link_pkg.sv
design/rio_local_bus_if.sv
design/rio_host.sv
design/rio_target.sv
design/rio_regs.sv
design/rio_top.sv
verification/rio_clock_gen.sv
verification/rio_assertions.sv
verification/rio_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the remote-IO testbench with Verilator and runs it.
# The result is decided by searching the log for the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f compile.f \
   --top-module rio_tb --Mdir "$OBJ" -o rio_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$OBJ/rio_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
   echo "result: FAIL"
   exit 1
fi

echo "result: PASS"
exit 0
